// ==== logic/mem_pkg.sv ====
// Shared types and constants for the RV32I data-side memory block
// Address map assumes data memory at 0x0000_0000..0x0000_0FFF and
// peripheral registers at the top of the 32-bit space
// Access size codes follow the low two bits of funct3; size 2'b11 is reserved
// and never writes

`default_nettype none

package mem_pkg;

    // Clocking
    localparam int CLK_FREQ_HZ  = 12_000_000;
    localparam int TICKS_PER_US = CLK_FREQ_HZ / 1_000_000;
    localparam int TICKS_PER_MS = CLK_FREQ_HZ / 1_000;

    // Data memory geometry, one entry per 32-bit word
    localparam int DMEM_WORDS = 1024;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    typedef logic [31:0] word_t;

    // Peripheral register addresses
    localparam word_t LEDS_ADDR   = 32'hFFFF_FFFC; // R/W duty bytes
    localparam word_t MILLIS_ADDR = 32'hFFFF_FFF8; // R only
    localparam word_t MICROS_ADDR = 32'hFFFF_FFF4; // R only

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } size_e;

    // Same bit order as funct3
    typedef struct packed {
        logic  is_unsigned;
        size_e size;
    } access_t;

    typedef struct packed {
        logic    wren;
        access_t access;
        word_t   addr;
        word_t   wdata;
    } mem_req_t;

    // One word seen as bytes or halfwords
    typedef union packed {
        word_t                word;
        logic [3:0][7:0]      bytes;
        logic [1:0][15:0]     halves;
    } word_lanes_t;

    typedef struct packed {
        logic [3:0]  be;   // Byte enables, bit i for bytes[i]
        word_lanes_t data; // Store data already shifted to its lanes
    } lane_write_t;

    typedef struct packed {
        logic led;
        logic red;
        logic green;
        logic blue;
    } led_pwm_t;

    // Steer store data onto byte lanes; no lanes enabled for a load
    function automatic lane_write_t store_lanes(input mem_req_t req);
        lane_write_t lw;
        lw.be        = 4'b0000;
        lw.data.word = '0;
        case (req.access.size)
            SIZE_WORD: begin
                lw.be        = 4'b1111;
                lw.data.word = req.wdata;
            end
            SIZE_HALF: begin
                lw.be = req.addr[1] ? 4'b1100 : 4'b0011;
                lw.data.halves[req.addr[1]] = req.wdata[15:0];
            end
            SIZE_BYTE: begin
                lw.be[req.addr[1:0]]         = 1'b1;
                lw.data.bytes[req.addr[1:0]] = req.wdata[7:0];
            end
            default: ; // Reserved size, nothing written
        endcase
        if (!req.wren) begin
            lw.be = 4'b0000;
        end
        return lw;
    endfunction

endpackage

`default_nettype wire

// ==== logic/dmem_bank.sv ====
// 4 kB data memory as a byte-lane masked RAM, one cycle read latency
// Only addresses with the upper 20 bits clear are decoded; others neither
// write nor read, so the 4 kB does not alias higher up
// Read data holds its last value during a store cycle

`default_nettype none

module dmem_bank (
    input  wire logic              clk,
    input  wire mem_pkg::mem_req_t req,
    output mem_pkg::word_lanes_t   rdata
);

    logic                        in_range;
    logic                        in_range_q;
    logic [mem_pkg::DMEM_AW-1:0] idx;
    mem_pkg::lane_write_t        lw;
    mem_pkg::word_t              rd_q;

    // Storage, one byte per lane
    logic [3:0][7:0] ram [mem_pkg::DMEM_WORDS];

    assign in_range = (req.addr[31:12] == 20'd0);
    assign idx      = req.addr[mem_pkg::DMEM_AW+1:2]; // Word index, bits 11:2
    assign lw       = mem_pkg::store_lanes(req);

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (in_range && lw.be[i]) begin
                ram[idx][i] <= lw.data.bytes[i];
            end
        end
        if (!req.wren) begin
            rd_q <= ram[idx];
        end
    end

    // Remember whether the word being returned came from our range
    always_ff @(posedge clk) begin
        in_range_q <= in_range;
    end

    assign rdata.word = in_range_q ? rd_q : '0; // Zero so the aligner can OR

endmodule

`default_nettype wire

// ==== logic/io_regs.sv ====
// Memory-mapped peripherals: LED duty register, four PWM channels and the
// micros / millis timers
// Timers are read-only and wrap mod 2^32; stores to them are dropped
// PWM period is 256 clocks from one free-running counter
// All state here is cleared by the synchronous rst

`default_nettype none

module io_regs (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire mem_pkg::mem_req_t req,
    output mem_pkg::word_t         rdata,
    output mem_pkg::led_pwm_t      pwm
);

    logic                 is_leds;
    logic                 is_millis;
    logic                 is_micros;
    mem_pkg::lane_write_t lw;
    mem_pkg::word_lanes_t leds;    // Bytes 3..0 = led, red, green, blue duty
    logic [7:0]           pwm_cnt;

    // Word-granular decode, low two bits select a lane only
    assign is_leds   = (req.addr[31:2] == mem_pkg::LEDS_ADDR[31:2]);
    assign is_millis = (req.addr[31:2] == mem_pkg::MILLIS_ADDR[31:2]);
    assign is_micros = (req.addr[31:2] == mem_pkg::MICROS_ADDR[31:2]);

    assign lw = mem_pkg::store_lanes(req);

    // Duty register, written lane by lane
    always_ff @(posedge clk) begin
        if (rst) begin
            leds.word <= '0;
        end else if (is_leds) begin
            for (int i = 0; i < 4; i++) begin
                if (lw.be[i]) begin
                    leds.bytes[i] <= lw.data.bytes[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pwm_cnt <= 8'd0;
        end else begin
            pwm_cnt <= pwm_cnt + 8'd1; // Wraps every 256 cycles
        end
    end

    // High for exactly duty cycles out of 256
    always_comb begin
        pwm.led   = (pwm_cnt < leds.bytes[3]);
        pwm.red   = (pwm_cnt < leds.bytes[2]);
        pwm.green = (pwm_cnt < leds.bytes[1]);
        pwm.blue  = (pwm_cnt < leds.bytes[0]);
    end

    // Timer 0 counts microseconds, timer 1 milliseconds
    for (genvar t = 0; t < 2; t++) begin : g_timer
        logic [$clog2(mem_pkg::TICKS_PER_MS)-1:0] div; // Prescaler
        logic                                     wrap;
        mem_pkg::word_t                           count;

        assign wrap = (int'(div) ==
            ((t == 0) ? mem_pkg::TICKS_PER_US : mem_pkg::TICKS_PER_MS) - 1);

        always_ff @(posedge clk) begin
            if (rst) begin
                div   <= '0;
                count <= '0;
            end else if (wrap) begin
                div   <= '0;
                count <= count + 32'd1;
            end else begin
                div <= div + 1'b1;
            end
        end
    end

    // Registered read word, zero outside our three registers
    always_ff @(posedge clk) begin
        if (is_leds) begin
            rdata <= leds.word;
        end else if (is_millis) begin
            rdata <= g_timer[1].count;
        end else if (is_micros) begin
            rdata <= g_timer[0].count;
        end else begin
            rdata <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/load_align.sv ====
// Load data path: merges the registered read words of the data memory and
// the peripherals, then extracts and extends the addressed byte or halfword
// Relies on both sources driving zero when the address was not theirs
// Misaligned halfword and word loads are not detected

`default_nettype none

module load_align (
    input  wire logic                 clk,
    input  wire mem_pkg::mem_req_t    req,
    input  wire mem_pkg::word_lanes_t dmem_rdata,
    input  wire mem_pkg::word_t       io_rdata,
    output mem_pkg::word_t            load_data
);

    mem_pkg::access_t     access_q;
    logic [1:0]           offset_q;
    mem_pkg::word_lanes_t merged;
    logic [15:0]          half_sel;
    logic [7:0]           byte_sel;
    logic                 sign_half;
    logic                 sign_byte;

    // Line up access code and offset with the registered read data
    always_ff @(posedge clk) begin
        access_q <= req.access;
        offset_q <= req.addr[1:0];
    end

    assign merged.word = dmem_rdata.word | io_rdata;

    assign half_sel  = merged.halves[offset_q[1]];
    assign byte_sel  = merged.bytes[offset_q];
    assign sign_half = half_sel[15] & ~access_q.is_unsigned;
    assign sign_byte = byte_sel[7] & ~access_q.is_unsigned;

    always_comb begin
        case (access_q.size)
            mem_pkg::SIZE_WORD: load_data = merged.word;
            mem_pkg::SIZE_HALF: load_data = {{16{sign_half}}, half_sel};
            default:            load_data = {{24{sign_byte}}, byte_sel}; // Byte
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/mem_top.sv ====
// Data-side memory block of a small RV32I core
// Single-cycle request port: every cycle is a request, always ready
// Load data is valid one cycle after the address, and unspecified after a
// store cycle

`default_nettype none

module mem_top (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire mem_pkg::mem_req_t req,
    output mem_pkg::word_t         load_data,
    output mem_pkg::led_pwm_t      pwm
);

    mem_pkg::word_lanes_t dmem_rdata;
    mem_pkg::word_t       io_rdata;

    dmem_bank dmem_bank_i (
        .clk   (clk),
        .req   (req),
        .rdata (dmem_rdata)
    );

    io_regs io_regs_i (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .rdata (io_rdata),
        .pwm   (pwm)
    );

    // Both read words arrive together, one cycle after req
    load_align load_align_i (
        .clk        (clk),
        .req        (req),
        .dmem_rdata (dmem_rdata),
        .io_rdata   (io_rdata),
        .load_data  (load_data)
    );

endmodule

`default_nettype wire

// ==== tests/tb_checks.svh ====
// Compare tasks and pass/fail counters for the memory block testbench
// Included inside the testbench module, needs mem_pkg compiled first
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int pass_count = 0;
int fail_count = 0;

// Exact compare when tol is zero, otherwise accepts a distance up to tol
task automatic check_word(input string name, input mem_pkg::word_t got,
                          input mem_pkg::word_t exp, input int unsigned tol);
    mem_pkg::word_t diff;
    diff = (got > exp) ? got - exp : exp - got;
    if ((^got === 1'bx) || (diff > tol)) begin
        fail_count++;
        $display("MISMATCH %s: load_data = %08h, expected %08h", name, got, exp);
    end else begin
        pass_count++;
        $display("ok %s: load_data = %08h", name, got);
    end
endtask

// High cycles of one channel over a 256-cycle window must equal its duty
task automatic check_pwm_count(input string chan, input int got, input logic [7:0] duty);
    if (got != int'(duty)) begin
        fail_count++;
        $display("MISMATCH %s high count: got %03h, expected %03h", chan, got, duty);
    end else begin
        pass_count++;
        $display("ok %s high for %0d of 256 cycles", chan, got);
    end
endtask

`endif

// ==== tests/tb_mem_top.sv ====
// Testbench for the data-side memory block
// Inputs change on the falling edge, load data is sampled one falling edge later
// Timer checks allow one count of slack against the cycle counter

`default_nettype none

module tb_mem_top;

    `include "tb_checks.svh"

    localparam int CLK_PERIOD = 100;

    localparam mem_pkg::access_t ACC_W  = '{is_unsigned: 1'b0, size: mem_pkg::SIZE_WORD};
    localparam mem_pkg::access_t ACC_H  = '{is_unsigned: 1'b0, size: mem_pkg::SIZE_HALF};
    localparam mem_pkg::access_t ACC_HU = '{is_unsigned: 1'b1, size: mem_pkg::SIZE_HALF};
    localparam mem_pkg::access_t ACC_B  = '{is_unsigned: 1'b0, size: mem_pkg::SIZE_BYTE};
    localparam mem_pkg::access_t ACC_BU = '{is_unsigned: 1'b1, size: mem_pkg::SIZE_BYTE};

    localparam mem_pkg::mem_req_t IDLE_REQ =
        '{wren: 1'b0, access: ACC_W, addr: 32'h0000_1000, wdata: 32'h0};

    localparam mem_pkg::word_t EXT_WORD    = 32'h7F8A_C305; // Mixed sign bits per byte and half
    localparam mem_pkg::word_t LEDS_MERGED = 32'h60A0_1020; // led, red, green, blue

    logic                clk = 1'b0;
    logic                rst;
    mem_pkg::mem_req_t   req;
    mem_pkg::word_t      load_data;
    mem_pkg::led_pwm_t   pwm;

    // Stimulus table, one entry per row in each queue
    string               names[$];
    mem_pkg::mem_req_t   reqs[$];
    mem_pkg::word_t      exps[$];
    bit                  rows_ready = 1'b0;
    int                  cycle_cnt;  // Rising edges since rst fell
    integer              seed = 32'hf7c4_7839;

    mem_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .load_data (load_data),
        .pwm       (pwm)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        if (rst) cycle_cnt <= 0;
        else     cycle_cnt <= cycle_cnt + 1;
    end

    task automatic add_row(input string name, input bit wren, input mem_pkg::access_t acc,
                           input mem_pkg::word_t addr, input mem_pkg::word_t wdata,
                           input mem_pkg::word_t exp);
        names.push_back(name);
        reqs.push_back('{wren: wren, access: acc, addr: addr, wdata: wdata});
        exps.push_back(exp);
    endtask

    task automatic build_table();
        mem_pkg::word_t rt_addr[4];
        mem_pkg::word_t rnd[4];
        rt_addr = '{32'h0000_0000, 32'h0000_0100, 32'h0000_03A0, 32'h0000_0FFC};
        for (int k = 0; k < 4; k++) begin
            rnd[k] = $random(seed);
            add_row($sformatf("round trip store %0d", k), 1, ACC_W, rt_addr[k], rnd[k], 0);
        end
        for (int k = 0; k < 4; k++)
            add_row($sformatf("round trip load %0d", k), 0, ACC_W, rt_addr[k], 0, rnd[k]);
        // Only the low byte or halfword of wdata may land
        add_row("merge base word", 1, ACC_W, 32'h0000_0040, 32'h1122_3344, 0);
        add_row("merge byte 3", 1, ACC_B, 32'h0000_0043, 32'h5566_77AA, 0);
        add_row("merge half 0", 1, ACC_H, 32'h0000_0040, 32'h1234_BEEF, 0);
        add_row("merge load", 0, ACC_W, 32'h0000_0040, 0, 32'hAA22_BEEF);
        add_row("ext store", 1, ACC_W, 32'h0000_0080, EXT_WORD, 0);
        add_row("lb off 0", 0, ACC_B, 32'h0000_0080, 0, 32'h0000_0005);
        add_row("lb off 1", 0, ACC_B, 32'h0000_0081, 0, 32'hFFFF_FFC3);
        add_row("lb off 2", 0, ACC_B, 32'h0000_0082, 0, 32'hFFFF_FF8A);
        add_row("lb off 3", 0, ACC_B, 32'h0000_0083, 0, 32'h0000_007F);
        add_row("lbu off 0", 0, ACC_BU, 32'h0000_0080, 0, 32'h0000_0005);
        add_row("lbu off 1", 0, ACC_BU, 32'h0000_0081, 0, 32'h0000_00C3);
        add_row("lbu off 2", 0, ACC_BU, 32'h0000_0082, 0, 32'h0000_008A);
        add_row("lbu off 3", 0, ACC_BU, 32'h0000_0083, 0, 32'h0000_007F);
        add_row("lh off 0", 0, ACC_H, 32'h0000_0080, 0, 32'hFFFF_C305);
        add_row("lh off 2", 0, ACC_H, 32'h0000_0082, 0, 32'h0000_7F8A);
        add_row("lhu off 0", 0, ACC_HU, 32'h0000_0080, 0, 32'h0000_C305);
        add_row("lhu off 2", 0, ACC_HU, 32'h0000_0082, 0, 32'h0000_7F8A);
        // 0x1004 would alias word 1 if the upper bits were not decoded
        add_row("unmapped base", 1, ACC_W, 32'h0000_0004, 32'hCAFE_F00D, 0);
        add_row("unmapped store", 1, ACC_W, 32'h0000_1004, 32'hDEAD_BEEF, 0);
        add_row("alias unchanged", 0, ACC_W, 32'h0000_0004, 0, 32'hCAFE_F00D);
        add_row("unmapped 0x2000", 0, ACC_W, 32'h0000_2000, 0, 32'h0);
        add_row("unmapped 0x8000_0000", 0, ACC_W, 32'h8000_0000, 0, 32'h0);
        add_row("leds word", 1, ACC_W, mem_pkg::LEDS_ADDR, 32'h4080_C020, 0);
        add_row("leds byte 1", 1, ACC_B, mem_pkg::LEDS_ADDR + 1, 32'h0000_0010, 0);
        add_row("leds half 1", 1, ACC_H, mem_pkg::LEDS_ADDR + 2, 32'h0000_60A0, 0);
        add_row("leds readback", 0, ACC_W, mem_pkg::LEDS_ADDR, 0, LEDS_MERGED);
    endtask

    // One request cycle followed by one idle cycle
    task automatic issue(input mem_pkg::mem_req_t r, output mem_pkg::word_t got);
        @(negedge clk);
        req = r;
        @(negedge clk);
        got = load_data; // Registered output, settled since the rising edge
        req = IDLE_REQ;
    endtask

    task automatic run_row(input int i);
        mem_pkg::word_t got;
        issue(reqs[i], got);
        if (!reqs[i].wren) check_word(names[i], got, exps[i], 0);
    endtask

    initial begin
        longint limit;
        wait (rows_ready);
        limit = longint'(names.size() * 4 + 256 * 4 + 3 * mem_pkg::TICKS_PER_MS);
        #(limit * CLK_PERIOD);
        $display("Timeout: tests still running after %0d clock cycles", limit);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        mem_pkg::word_t   got;
        mem_pkg::mem_req_t treq;
        int               hi[4];
        rst = 1'b1;
        req = IDLE_REQ;
        build_table();
        rows_ready = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < names.size(); i++) run_row(i);

        // Any 256-cycle window covers one full PWM period
        hi = '{0, 0, 0, 0};
        repeat (256) begin
            @(negedge clk);
            hi[0] += pwm.led;
            hi[1] += pwm.red;
            hi[2] += pwm.green;
            hi[3] += pwm.blue;
        end
        check_pwm_count("pwm.led", hi[0], LEDS_MERGED[31:24]);
        check_pwm_count("pwm.red", hi[1], LEDS_MERGED[23:16]);
        check_pwm_count("pwm.green", hi[2], LEDS_MERGED[15:8]);
        check_pwm_count("pwm.blue", hi[3], LEDS_MERGED[7:0]);

        repeat (2 * mem_pkg::TICKS_PER_MS) @(negedge clk);
        treq = '{wren: 1'b0, access: ACC_W, addr: mem_pkg::MICROS_ADDR, wdata: 32'h0};
        issue(treq, got);
        check_word("micros", got, mem_pkg::word_t'(cycle_cnt / mem_pkg::TICKS_PER_US), 1);
        treq.addr = mem_pkg::MILLIS_ADDR;
        issue(treq, got);
        check_word("millis", got, mem_pkg::word_t'(cycle_cnt / mem_pkg::TICKS_PER_MS), 1);

        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+tests
logic/mem_pkg.sv
logic/dmem_bank.sv
logic/io_regs.sv
logic/load_align.sv
logic/mem_top.sv
tests/tb_mem_top.sv

// ==== Bender.yml ====
package:
  name: mem_top

sources:
  - logic/mem_pkg.sv
  - logic/dmem_bank.sv
  - logic/io_regs.sv
  - logic/load_align.sv
  - logic/mem_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_mem_top.sv
